/* include/soc_params.svh */
// --------------------
// System constants shared by RTL and testbench
// Bank count must stay below SOC_IRQ_BANK
// Reset hold is short for simulation only
// --------------------
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus and CSR data width
`define SOC_DATA_W 32

// CSR word address split, bank on top
`define SOC_CSR_BANK_W 4
`define SOC_CSR_REG_W 10

// Timer banks sit at banks 0 and up
`define SOC_NUM_TIMERS 4
`define SOC_IRQ_BANK 15

// Cycles of reset after the trigger falls
`define SOC_RST_HOLD 64

`endif

/* source/wb_pkg.sv */
// --------------------
// System bus types, classic cyc/stb/ack strobes
// Word addressed, no byte selects and no bursts
// --------------------
`include "soc_params.svh"

package wb_pkg;

	// Request from the bus master
	// adr is bus address bits 15:2
	typedef struct packed {
		logic [`SOC_CSR_BANK_W+`SOC_CSR_REG_W-1:0] adr;
		logic [`SOC_DATA_W-1:0] dat;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	// Response back to the master
	typedef struct packed {
		logic [`SOC_DATA_W-1:0] dat;
		logic ack;
	} wb_rsp_t;

endpackage

/* source/csr_pkg.sv */
// --------------------
// CSR side types
// Address is one word, seen raw or as bank and register
// --------------------
`include "soc_params.svh"

package csr_pkg;

	// Decoded view of a CSR word address
	typedef struct packed {
		logic [`SOC_CSR_BANK_W-1:0] bank;
		logic [`SOC_CSR_REG_W-1:0] reg_idx;
	} csr_field_t;

	// Bridge fills raw, banks read field
	typedef union packed {
		logic [`SOC_CSR_BANK_W+`SOC_CSR_REG_W-1:0] raw;
		csr_field_t field;
	} csr_addr_u;

	// One access, stb high for a single cycle
	typedef struct packed {
		csr_addr_u addr;
		logic we;
		logic [`SOC_DATA_W-1:0] wdata;
		logic stb;
	} csr_req_t;

	// Timer bank registers, CTRL bit 0 is enable
	typedef enum logic [`SOC_CSR_REG_W-1:0] {
		CTRL = 0,
		RELOAD = 1,
		COUNT = 2
	} timer_reg_e;

	// Interrupt controller registers
	typedef enum logic [`SOC_CSR_REG_W-1:0] {
		PENDING = 0,
		MASK = 1
	} irq_reg_e;

endpackage

/* source/reset_gen.sv */
`timescale 1ns/10ps
// --------------------
// Held system reset from a trigger
// Trigger must already be in the sys_clk domain
// Hold length set by SOC_RST_HOLD
// --------------------
`include "soc_params.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic trigger_reset,
	output logic sys_rst_o,
	output logic periph_rst_n_o
);

	// Counter wide enough for the full hold
	localparam int CNT_W = $clog2(`SOC_RST_HOLD + 1);

	logic [CNT_W-1:0] hold_cnt;
	logic rst_next;

	// Still in reset while trigger high or count running
	assign rst_next = trigger_reset | (hold_cnt != '0);

	// --------------------
	// Hold counter
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			// Reload for as long as the trigger stays high
			hold_cnt <= CNT_W'(`SOC_RST_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// --------------------
	// Registered outputs
	// --------------------
	always_ff @(posedge sys_clk) begin
		sys_rst_o <= rst_next;
		// Same edge as sys_rst_o, opposite polarity
		periph_rst_n_o <= ~rst_next;
	end

endmodule

/* source/csr_bridge.sv */
`timescale 1ns/10ps
// --------------------
// System bus to CSR bridge
// One transaction at a time with fixed latency
// Ack comes two edges after stb is sampled and lasts one cycle
// Master may only stall by holding stb low
// --------------------
`include "soc_params.svh"

module csr_bridge (
	input  logic                   sys_clk,
	input  logic                   sys_rst_i,
	input  wb_pkg::wb_req_t        wb_req_i,
	output wb_pkg::wb_rsp_t        wb_rsp_o,
	output csr_pkg::csr_req_t      csr_req_o,
	input  logic [`SOC_DATA_W-1:0] csr_rdata_i
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_ACCESS,
		S_WAIT,
		S_ACK,
		S_RECOVER
	} state_t;

	state_t state;
	logic start;

	// Latched request payload
	csr_pkg::csr_addr_u addr_q;
	logic we_q;
	logic [`SOC_DATA_W-1:0] wdata_q;
	logic [`SOC_DATA_W-1:0] rdata_q;

	assign start = (state == S_IDLE) & wb_req_i.cyc & wb_req_i.stb;

	// --------------------
	// Control FSM
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (start) state <= S_ACCESS;
				// Strobe to banks for this one cycle
				S_ACCESS: state <= S_WAIT;
				// Banks register readback during this cycle
				S_WAIT: state <= S_ACK;
				S_ACK: state <= S_RECOVER;
				// Ignore stb if the master still holds it
				S_RECOVER: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// --------------------
	// Payload capture
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			// Clear payload and readback
			addr_q <= '0;
			we_q <= 1'b0;
			wdata_q <= '0;
			rdata_q <= '0;
		end else begin
			if (start) begin
				addr_q.raw <= wb_req_i.adr;
				we_q <= wb_req_i.we;
				wdata_q <= wb_req_i.dat;
			end
			// OR of all banks is valid on this edge
			if (state == S_WAIT)
				rdata_q <= csr_rdata_i;
		end
	end

	// Outputs decoded from state
	always_comb begin
		csr_req_o.addr = addr_q;
		csr_req_o.we = we_q;
		csr_req_o.wdata = wdata_q;
		csr_req_o.stb = (state == S_ACCESS);
		wb_rsp_o.dat = rdata_q;
		wb_rsp_o.ack = (state == S_ACK);
	end

endmodule

/* source/timer_bank.sv */
`timescale 1ns/10ps
// --------------------
// Countdown timer as one CSR bank
// Auto reload, one-cycle irq pulse at zero
// RELOAD of zero pulses every cycle
// Readback zero unless this bank is read
// --------------------
`include "soc_params.svh"

module timer_bank #(
	parameter int BANK_ID = 0
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_i,
	input  csr_pkg::csr_req_t      csr_req_i,
	output logic [`SOC_DATA_W-1:0] rdata_o,
	output logic                   irq_o
);

	localparam logic [`SOC_CSR_BANK_W-1:0] BANK_SEL = BANK_ID[`SOC_CSR_BANK_W-1:0];

	logic bank_hit;
	logic wr_ctrl;
	logic wr_reload;
	logic rd_hit;

	// Register state
	logic enable;
	logic [`SOC_DATA_W-1:0] reload;
	logic [`SOC_DATA_W-1:0] count;
	logic irq_q;
	logic [`SOC_DATA_W-1:0] rdata_q;

	// --------------------
	// Address decode
	// --------------------
	assign bank_hit = csr_req_i.stb & (csr_req_i.addr.field.bank == BANK_SEL);
	assign wr_ctrl = bank_hit & csr_req_i.we
		& (csr_req_i.addr.field.reg_idx == csr_pkg::CTRL);
	assign wr_reload = bank_hit & csr_req_i.we
		& (csr_req_i.addr.field.reg_idx == csr_pkg::RELOAD);
	// COUNT has no write path
	assign rd_hit = bank_hit & ~csr_req_i.we;

	// --------------------
	// Timer core
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			enable <= 1'b0;
			reload <= '0;
			count <= '0;
			irq_q <= 1'b0;
		end else begin
			irq_q <= 1'b0;
			if (wr_ctrl) begin
				// Bit 0 is enable, setting it restarts the count
				enable <= csr_req_i.wdata[0];
				if (csr_req_i.wdata[0])
					count <= reload;
			end else if (enable) begin
				if (count == '0) begin
					count <= reload;
					irq_q <= 1'b1;
				end else begin
					count <= count - 1'b1;
				end
			end
			if (wr_reload)
				reload <= csr_req_i.wdata;
		end
	end

	// --------------------
	// Readback
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			rdata_q <= '0;
		end else begin
			rdata_q <= '0;
			if (rd_hit) begin
				case (csr_req_i.addr.field.reg_idx)
					csr_pkg::CTRL: rdata_q <= {{(`SOC_DATA_W-1){1'b0}}, enable};
					csr_pkg::RELOAD: rdata_q <= reload;
					csr_pkg::COUNT: rdata_q <= count;
					// Unknown index reads zero
					default: rdata_q <= '0;
				endcase
			end
		end
	end

	assign rdata_o = rdata_q;
	assign irq_o = irq_q;

endmodule

/* source/irq_ctrl.sv */
`timescale 1ns/10ps
// --------------------
// Interrupt controller, CSR bank SOC_IRQ_BANK
// PENDING is write-1-to-clear, new pulse wins
// irq_o lags PENDING by one cycle
// Also the read data OR for all banks
// --------------------
`include "soc_params.svh"

module irq_ctrl (
	input  logic                                          sys_clk,
	input  logic                                          sys_rst_i,
	input  csr_pkg::csr_req_t                             csr_req_i,
	input  logic [`SOC_NUM_TIMERS-1:0][`SOC_DATA_W-1:0]   bank_rdata_i,
	input  logic [`SOC_NUM_TIMERS-1:0]                    bank_irq_i,
	output logic [`SOC_DATA_W-1:0]                        rdata_o,
	output logic                                          irq_o
);

	localparam logic [`SOC_CSR_BANK_W-1:0] IRQ_BANK = `SOC_CSR_BANK_W'(`SOC_IRQ_BANK);

	logic bank_hit;
	logic wr_pending;
	logic wr_mask;

	logic [`SOC_NUM_TIMERS-1:0] pending;
	logic [`SOC_NUM_TIMERS-1:0] mask;
	logic [`SOC_NUM_TIMERS-1:0] clr_bits;
	logic irq_q;
	logic [`SOC_DATA_W-1:0] rdata_q;

	assign bank_hit = csr_req_i.stb & (csr_req_i.addr.field.bank == IRQ_BANK);
	assign wr_pending = bank_hit & csr_req_i.we
		& (csr_req_i.addr.field.reg_idx == csr_pkg::PENDING);
	assign wr_mask = bank_hit & csr_req_i.we
		& (csr_req_i.addr.field.reg_idx == csr_pkg::MASK);
	assign clr_bits = wr_pending ? csr_req_i.wdata[`SOC_NUM_TIMERS-1:0] : '0;

	// --------------------
	// Pending, mask and irq
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			pending <= '0;
			mask <= '0;
			irq_q <= 1'b0;
		end else begin
			// Set after clear so a same-cycle pulse is kept
			pending <= (pending & ~clr_bits) | bank_irq_i;
			if (wr_mask)
				mask <= csr_req_i.wdata[`SOC_NUM_TIMERS-1:0];
			irq_q <= |(pending & mask);
		end
	end

	// Own readback, zero when not addressed
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			rdata_q <= '0;
		end else begin
			rdata_q <= '0;
			if (bank_hit & ~csr_req_i.we) begin
				case (csr_req_i.addr.field.reg_idx)
					csr_pkg::PENDING: rdata_q <= `SOC_DATA_W'(pending);
					csr_pkg::MASK: rdata_q <= `SOC_DATA_W'(mask);
					default: rdata_q <= '0;
				endcase
			end
		end
	end

	// --------------------
	// Read data OR
	// --------------------
	always_comb begin
		rdata_o = rdata_q;
		for (int i = 0; i < `SOC_NUM_TIMERS; i++)
			rdata_o = rdata_o | bank_rdata_i[i];
	end

	assign irq_o = irq_q;

endmodule

/* source/soc_top.sv */
`timescale 1ns/10ps
// --------------------
// CSR backbone top level
// Timer banks at 0 and up, irq_ctrl at SOC_IRQ_BANK
// Unmapped banks read zero
// --------------------
`include "soc_params.svh"

module soc_top (
	input  logic            sys_clk,
	input  logic            trigger_reset,
	input  wb_pkg::wb_req_t wb_req_i,
	output wb_pkg::wb_rsp_t wb_rsp_o,
	output logic            irq_o,
	output logic            periph_rst_n_o
);

	logic sys_rst;
	csr_pkg::csr_req_t csr_req;
	logic [`SOC_DATA_W-1:0] csr_rdata;
	logic [`SOC_NUM_TIMERS-1:0][`SOC_DATA_W-1:0] timer_rdata;
	logic [`SOC_NUM_TIMERS-1:0] timer_irq;

	// Reset
	reset_gen u_reset_gen (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.sys_rst_o      (sys_rst),
		.periph_rst_n_o (periph_rst_n_o)
	);

	// Bus to CSR
	csr_bridge u_csr_bridge (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst),
		.wb_req_i    (wb_req_i),
		.wb_rsp_o    (wb_rsp_o),
		.csr_req_o   (csr_req),
		.csr_rdata_i (csr_rdata)
	);

	// --------------------
	// Timer banks
	// --------------------
	for (genvar g = 0; g < `SOC_NUM_TIMERS; g++) begin : gen_timer
		timer_bank #(
			.BANK_ID (g)
		) u_timer_bank (
			.sys_clk   (sys_clk),
			.sys_rst_i (sys_rst),
			.csr_req_i (csr_req),
			.rdata_o   (timer_rdata[g]),
			.irq_o     (timer_irq[g])
		);
	end

	// Interrupts and read data merge
	irq_ctrl u_irq_ctrl (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.csr_req_i    (csr_req),
		.bank_rdata_i (timer_rdata),
		.bank_irq_i   (timer_irq),
		.rdata_o      (csr_rdata),
		.irq_o        (irq_o)
	);

endmodule

/* testbench/soc_asserts.sv */
`timescale 1ns/10ps
// --------------------
// Bus and reset rules, bound into soc_top
// Ack rules are off while sys_rst is high
// --------------------

module soc_asserts (
	input logic            sys_clk,
	input logic            sys_rst_i,
	input wb_pkg::wb_req_t wb_req_i,
	input wb_pkg::wb_rsp_t wb_rsp_i,
	input logic            irq_i
);

	// Ack is a one-cycle pulse
	ack_one_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_rsp_i.ack |=> !wb_rsp_i.ack)
		else $error("ack high for two cycles");

	// Ack only inside a live bus cycle
	ack_in_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
		else $error("ack without cyc and stb");

	// irq_q clears one edge into reset
	irq_low_in_reset: assert property (@(posedge sys_clk)
		(sys_rst_i && $past(sys_rst_i)) |-> !irq_i)
		else $error("irq_o high during reset");

endmodule

bind soc_top soc_asserts u_soc_asserts (
	.sys_clk   (sys_clk),
	.sys_rst_i (sys_rst),
	.wb_req_i  (wb_req_i),
	.wb_rsp_i  (wb_rsp_o),
	.irq_i     (irq_o)
);

/* testbench/soc_tb.sv */
`timescale 1ns/10ps
// --------------------
// Testbench for soc_top, one bus master
// Inputs change and outputs are read on the falling edge
// Stimulus is a table built at start, applied in order
// --------------------
`include "soc_params.svh"

module soc_tb;

	localparam int ADR_W = `SOC_CSR_BANK_W + `SOC_CSR_REG_W;
	localparam int IRQ_B = `SOC_IRQ_BANK;
	localparam int BUS_TIMEOUT = 20;
	localparam int RST_TIMEOUT = `SOC_RST_HOLD + 16;
	// A COUNT read this low may see a reload before the next read
	localparam int RELOAD_GAP = 16;

	typedef enum logic [2:0] {
		OP_WRITE,
		OP_READ,
		OP_WAIT_IRQ,
		OP_NO_IRQ,
		OP_RESET,
		OP_COUNT
	} op_e;

	// One table row, rnd means random data or saved readback
	// OP_COUNT uses data as RELOAD and exp_val bit 0 as running
	typedef struct packed {
		op_e op;
		logic [ADR_W-1:0] addr;
		logic [`SOC_DATA_W-1:0] data;
		logic [`SOC_DATA_W-1:0] exp_val;
		logic rnd;
		int limit;
	} step_t;

	logic sys_clk;
	logic trigger_reset;
	wb_pkg::wb_req_t wb_req;
	wb_pkg::wb_rsp_t wb_rsp;
	logic irq;
	logic periph_rst_n;

	step_t steps[$];
	logic [`SOC_DATA_W-1:0] saved [logic [ADR_W-1:0]];
	integer seed = 32'hf377_3a4d;
	bit run_done = 1'b0;
	bit fail_shown = 1'b0;

	soc_top UUT (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.wb_req_i       (wb_req),
		.wb_rsp_o       (wb_rsp),
		.irq_o          (irq),
		.periph_rst_n_o (periph_rst_n)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// --------------------
	// Checks and failure
	// --------------------
	task automatic abort_run(input string why);
		fail_shown = 1'b1;
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_rsp(input wb_pkg::wb_rsp_t rsp, input logic [`SOC_DATA_W-1:0] exp_dat,
		input logic [ADR_W-1:0] addr);
		if (rsp.dat !== exp_dat)
			abort_run($sformatf("CHECK FAILED wb_rsp_o.dat addr %h got %h expected %h",
				addr, rsp.dat, exp_dat));
	endtask

	task automatic check_irq(input logic got, input logic exp_irq);
		if (got !== exp_irq)
			abort_run($sformatf("CHECK FAILED irq_o got %h expected %h", got, exp_irq));
	endtask

	// Bank and register into a bus word address
	function automatic logic [ADR_W-1:0] csr_addr(input int bank, input int idx);
		csr_pkg::csr_addr_u a;
		a.field.bank = bank[`SOC_CSR_BANK_W-1:0];
		a.field.reg_idx = idx[`SOC_CSR_REG_W-1:0];
		return a.raw;
	endfunction

	// --------------------
	// Bus and wait tasks
	// --------------------
	task automatic bus_access(input logic we, input logic [ADR_W-1:0] addr,
		input logic [`SOC_DATA_W-1:0] data, output wb_pkg::wb_rsp_t rsp);
		int waited;
		wb_req.adr = addr;
		wb_req.dat = data;
		wb_req.we = we;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		waited = 0;
		@(negedge sys_clk);
		while (wb_rsp.ack !== 1'b1) begin
			if (waited == BUS_TIMEOUT)
				abort_run("No ack from the bus bridge within the timeout");
			@(negedge sys_clk);
			waited++;
		end
		rsp = wb_rsp;
		// Strobes held through ack, dropped one cycle later
		@(negedge sys_clk);
		wb_req = '0;
	endtask

	task automatic wait_irq(input int limit);
		int waited;
		waited = 0;
		while (irq !== 1'b1) begin
			if (waited == limit)
				abort_run("irq_o did not rise within the timeout");
			@(negedge sys_clk);
			waited++;
		end
	endtask

	task automatic watch_no_irq(input int limit);
		repeat (limit) begin
			@(negedge sys_clk);
			check_irq(irq, 1'b0);
		end
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (periph_rst_n !== 1'b1) begin
			if (waited == RST_TIMEOUT)
				abort_run("Reset did not release within the timeout");
			@(negedge sys_clk);
			waited++;
		end
	endtask

	task automatic pulse_reset(input int hold);
		int waited;
		trigger_reset = 1'b1;
		waited = 0;
		@(negedge sys_clk);
		while (periph_rst_n !== 1'b0) begin
			if (waited == 4)
				abort_run("periph_rst_n_o did not fall after the reset trigger");
			@(negedge sys_clk);
			waited++;
		end
		// irq_q is cleared one edge after sys_rst rises
		@(negedge sys_clk);
		check_irq(irq, 1'b0);
		repeat (hold) @(negedge sys_clk);
		trigger_reset = 1'b0;
		wait_reset_release();
	endtask

	task automatic check_count(input logic [ADR_W-1:0] addr,
		input logic [`SOC_DATA_W-1:0] reload, input logic running);
		wb_pkg::wb_rsp_t first;
		wb_pkg::wb_rsp_t second;
		logic ok;
		bus_access(1'b0, addr, '0, first);
		bus_access(1'b0, addr, '0, second);
		if (running)
			ok = (second.dat < first.dat) || (first.dat < RELOAD_GAP && second.dat <= reload);
		else
			ok = (second.dat == first.dat);
		if (!ok)
			abort_run($sformatf("CHECK FAILED COUNT addr %h first %h second %h",
				addr, first.dat, second.dat));
	endtask

	// --------------------
	// Stimulus table
	// --------------------
	task automatic push_step(input op_e op, input logic [ADR_W-1:0] addr,
		input logic [`SOC_DATA_W-1:0] data, input logic [`SOC_DATA_W-1:0] exp_val,
		input logic rnd, input int limit);
		step_t st;
		st.op = op;
		st.addr = addr;
		st.data = data;
		st.exp_val = exp_val;
		st.rnd = rnd;
		st.limit = limit;
		steps.push_back(st);
	endtask

	// Every mapped register zero and no interrupt
	task automatic expect_all_zero();
		for (int b = 0; b < `SOC_NUM_TIMERS; b++)
			for (int r = 0; r < 3; r++)
				push_step(OP_READ, csr_addr(b, r), '0, '0, 1'b0, 0);
		push_step(OP_READ, csr_addr(IRQ_B, 0), '0, '0, 1'b0, 0);
		push_step(OP_READ, csr_addr(IRQ_B, 1), '0, '0, 1'b0, 0);
		push_step(OP_NO_IRQ, '0, '0, '0, 1'b0, 20);
	endtask

	task automatic build_table();
		expect_all_zero();
		// Random RELOAD per bank, then full readback
		for (int b = 0; b < `SOC_NUM_TIMERS; b++)
			push_step(OP_WRITE, csr_addr(b, 1), '0, '0, 1'b1, 0);
		for (int b = 0; b < `SOC_NUM_TIMERS; b++) begin
			push_step(OP_READ, csr_addr(b, 1), '0, '0, 1'b1, 0);
			push_step(OP_READ, csr_addr(b, 0), '0, '0, 1'b0, 0);
			push_step(OP_READ, csr_addr(b, 2), '0, '0, 1'b0, 0);
		end
		// Unmapped banks, unknown indices
		for (int b = `SOC_NUM_TIMERS; b < IRQ_B; b++) begin
			push_step(OP_READ, csr_addr(b, 0), '0, '0, 1'b0, 0);
			push_step(OP_READ, csr_addr(b, 1), '0, '0, 1'b0, 0);
		end
		push_step(OP_READ, csr_addr(0, 3), '0, '0, 1'b0, 0);
		push_step(OP_READ, csr_addr(3, 1023), '0, '0, 1'b0, 0);
		push_step(OP_READ, csr_addr(IRQ_B, 2), '0, '0, 1'b0, 0);
		push_step(OP_READ, csr_addr(IRQ_B, 1023), '0, '0, 1'b0, 0);
		// Bank 2 unmasked, clear then disable within one period
		push_step(OP_WRITE, csr_addr(IRQ_B, 1), 32'h4, '0, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(2, 1), 32'd50, '0, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(2, 0), 32'h1, '0, 1'b0, 0);
		push_step(OP_WAIT_IRQ, '0, '0, '0, 1'b0, 200);
		push_step(OP_READ, csr_addr(IRQ_B, 0), '0, 32'h4, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(IRQ_B, 0), 32'h4, '0, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(2, 0), 32'h0, '0, 1'b0, 0);
		push_step(OP_READ, csr_addr(IRQ_B, 0), '0, '0, 1'b0, 0);
		push_step(OP_NO_IRQ, '0, '0, '0, 1'b0, 100);
		// Bank 3 masked off
		push_step(OP_WRITE, csr_addr(IRQ_B, 1), 32'h0, '0, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(3, 1), 32'd10, '0, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(3, 0), 32'h1, '0, 1'b0, 0);
		push_step(OP_NO_IRQ, '0, '0, '0, 1'b0, 60);
		push_step(OP_WRITE, csr_addr(3, 0), 32'h0, '0, 1'b0, 0);
		push_step(OP_READ, csr_addr(IRQ_B, 0), '0, 32'h8, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(IRQ_B, 0), 32'h8, '0, 1'b0, 0);
		push_step(OP_READ, csr_addr(IRQ_B, 0), '0, '0, 1'b0, 0);
		// COUNT running, then frozen
		push_step(OP_WRITE, csr_addr(1, 1), 32'd1000, '0, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(1, 0), 32'h1, '0, 1'b0, 0);
		push_step(OP_COUNT, csr_addr(1, 2), 32'd1000, 32'h1, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(1, 0), 32'h0, '0, 1'b0, 0);
		push_step(OP_COUNT, csr_addr(1, 2), 32'd1000, 32'h0, 1'b0, 0);
		// Live interrupt, then reset mid run
		push_step(OP_WRITE, csr_addr(IRQ_B, 1), 32'h1, '0, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(0, 1), 32'd20, '0, 1'b0, 0);
		push_step(OP_WRITE, csr_addr(0, 0), 32'h1, '0, 1'b0, 0);
		push_step(OP_WAIT_IRQ, '0, '0, '0, 1'b0, 100);
		push_step(OP_RESET, '0, '0, '0, 1'b0, 8);
		expect_all_zero();
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		step_t st;
		wb_pkg::wb_rsp_t rsp;
		logic [`SOC_DATA_W-1:0] wdata;
		logic [`SOC_DATA_W-1:0] exp_dat;
		trigger_reset = 1'b1;
		wb_req = '0;
		repeat (16) @(negedge sys_clk);
		trigger_reset = 1'b0;
		wait_reset_release();
		build_table();
		foreach (steps[i]) begin
			st = steps[i];
			case (st.op)
				OP_WRITE: begin
					wdata = st.data;
					if (st.rnd) begin
						wdata = $random(seed);
						saved[st.addr] = wdata;
					end
					bus_access(1'b1, st.addr, wdata, rsp);
				end
				OP_READ: begin
					exp_dat = st.rnd ? saved[st.addr] : st.exp_val;
					bus_access(1'b0, st.addr, '0, rsp);
					check_rsp(rsp, exp_dat, st.addr);
				end
				OP_WAIT_IRQ: wait_irq(st.limit);
				OP_NO_IRQ: watch_no_irq(st.limit);
				OP_RESET: pulse_reset(st.limit);
				OP_COUNT: check_count(st.addr, st.data, st.exp_val[0]);
				default: abort_run("Unknown operation in the stimulus table");
			endcase
		end
		run_done = 1'b1;
		$display("Verification passed");
		$finish;
	end

	// Run stopped early, by an assertion for instance
	final begin
		if (!run_done && !fail_shown)
			$display("Verification failed");
	end

endmodule

/* sources.f */
+incdir+include
source/wb_pkg.sv
source/csr_pkg.sv
source/reset_gen.sv
source/csr_bridge.sv
source/timer_bank.sv
source/irq_ctrl.sv
source/soc_top.sv
testbench/soc_asserts.sv
testbench/soc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run soc_tb with Verilator, result taken from sim.log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module soc_tb -o soc_sim \
	&& ./obj_dir/soc_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
